/* rtl/apbGraphRegs.sv */
`timescale 1ns/1ps

module apbGraphRegs (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [apbRegPkg::apbAddrW-1:0] paddr,
    input logic [apbRegPkg::apbDataW-1:0] pwdata,
    output logic [apbRegPkg::apbDataW-1:0] prdata,
    output logic pready,
    output logic pslverr,
    output hypercubePkg::graphT graph,
    output logic start,
    input logic busy,
    input hypercubePkg::countT count
);
    import apbRegPkg::*;
    import hypercubePkg::*;

    logic access;
    logic mapped;
    logic graphHit;
    logic controlHit;
    logic statusHit;
    logic [1:0] wordSel;
    logic [apbDataW-1:0] status;
    logic [apbDataW-1:0] readData;
    logic writeErr;
    logic graphWrite;

    assign access = psel & penable;

    always_comb begin
        status = '0;
        status[statusBusyBit] = busy;
        status[statusCountLsb +: $bits(countT)] = count;
    end

    // Address decode and read mux
    always_comb begin
        mapped = 1'b1;
        graphHit = 1'b0;
        controlHit = 1'b0;
        statusHit = 1'b0;
        wordSel = '0;
        case (paddr)
            addrGraph0: begin
                graphHit = 1'b1;
                wordSel = 2'd0;
            end
            addrGraph1: begin
                graphHit = 1'b1;
                wordSel = 2'd1;
            end
            addrGraph2: begin
                graphHit = 1'b1;
                wordSel = 2'd2;
            end
            addrGraph3: begin
                graphHit = 1'b1;
                wordSel = 2'd3;
            end
            addrControl: controlHit = 1'b1;
            addrStatus: statusHit = 1'b1;
            default: mapped = 1'b0;
        endcase

        if (graphHit) begin
            readData = graph[apbDataW*wordSel +: apbDataW];
        end else if (statusHit) begin
            readData = status;
        end else begin
            readData = '0;
        end
    end

    // Status is read only, graph is frozen during a run
    assign writeErr = pwrite & (statusHit | (graphHit & busy));
    assign graphWrite = access & pwrite & graphHit & ~busy;

    assign pready = 1'b1;
    assign pslverr = access & (~mapped | writeErr);
    assign prdata = access ? readData : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            graph <= '0;
            start <= 1'b0;
        end else begin
            if (graphWrite) begin
                graph[apbDataW*wordSel +: apbDataW] <= pwdata;
            end
            // One-cycle pulse, dropped while a run is active
            start <= access & pwrite & controlHit & pwdata[0] & ~busy;
        end
    end

endmodule

/* rtl/apbRegPkg.sv */
package apbRegPkg;

    localparam int apbAddrW = 8;
    localparam int apbDataW = 32;

    // Graph words, lowest vertices in word 0
    localparam logic [apbAddrW-1:0] addrGraph0 = 8'h00;
    localparam logic [apbAddrW-1:0] addrGraph1 = 8'h04;
    localparam logic [apbAddrW-1:0] addrGraph2 = 8'h08;
    localparam logic [apbAddrW-1:0] addrGraph3 = 8'h0C;

    // Bit 0 written as 1 requests a run
    localparam logic [apbAddrW-1:0] addrControl = 8'h10;

    // Read only
    localparam logic [apbAddrW-1:0] addrStatus = 8'h14;

    localparam int statusBusyBit = 0;
    localparam int statusCountLsb = 8;

endpackage

/* rtl/componentController.sv */
`timescale 1ns/1ps

module componentController (
    input logic clk,
    input logic rst,
    input hypercubePkg::graphT graph,
    input logic start,
    output logic busy,
    output hypercubePkg::countT count,
    componentIf.ctrl cmp
);
    import hypercubePkg::*;

    enum logic [1:0] {
        sIdle,
        sSeed,
        sExpand
    } state;

    // Seeder output lags remaining by one register
    logic seedReady;

    // While expanding, the expander register feeds itself, one step per clock.
    // Otherwise the expander starts from the fresh seed
    assign cmp.frontier = (state == sExpand) ? cmp.extended : cmp.seed;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
            seedReady <= 1'b0;
            busy <= 1'b0;
            count <= '0;
            cmp.remaining <= '0;
        end else begin
            case (state)
                sIdle: begin
                    if (start) begin
                        cmp.remaining <= graph;
                        count <= '0;
                        busy <= 1'b1;
                        seedReady <= 1'b0;
                        state <= sSeed;
                    end
                end
                sSeed: begin
                    if (!seedReady) begin
                        seedReady <= 1'b1;
                    end else if (cmp.empty) begin
                        // Every vertex has been claimed
                        busy <= 1'b0;
                        state <= sIdle;
                    end else begin
                        state <= sExpand;
                    end
                end
                sExpand: begin
                    if (cmp.settled) begin
                        // extended holds the whole component here
                        cmp.remaining <= cmp.remaining & ~cmp.extended;
                        count <= count + countT'(1);
                        seedReady <= 1'b0;
                        state <= sSeed;
                    end
                end
                default: begin
                    busy <= 1'b0;
                    state <= sIdle;
                end
            endcase
        end
    end

endmodule

/* rtl/componentIf.sv */
`timescale 1ns/1ps

interface componentIf;
    import hypercubePkg::*;

    // Controller side
    graphT remaining;
    graphT frontier;

    // Seed finder side
    graphT seed;
    logic empty;

    // Expander side
    graphT extended;
    logic settled;

    modport ctrl (
        output remaining,
        output frontier,
        input seed,
        input empty,
        input extended,
        input settled
    );

    modport seeder (
        input remaining,
        output seed,
        output empty
    );

    modport expander (
        input remaining,
        input frontier,
        output extended,
        output settled
    );

endinterface

/* rtl/connectedCountTop.sv */
`timescale 1ns/1ps

module connectedCountTop (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [apbRegPkg::apbAddrW-1:0] paddr,
    input logic [apbRegPkg::apbDataW-1:0] pwdata,
    output logic [apbRegPkg::apbDataW-1:0] prdata,
    output logic pready,
    output logic pslverr
);
    import hypercubePkg::*;

    graphT graph;
    logic start;
    logic busy;
    countT count;

    componentIf cmp ();

    apbGraphRegs regs (
        .clk(clk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .graph(graph),
        .start(start),
        .busy(busy),
        .count(count)
    );

    componentController ctrl (
        .clk(clk),
        .rst(rst),
        .graph(graph),
        .start(start),
        .busy(busy),
        .count(count),
        .cmp(cmp.ctrl)
    );

    firstBitSeeder seeder (
        .clk(clk),
        .rst(rst),
        .cmp(cmp.seeder)
    );

    hypercubeExpander expander (
        .clk(clk),
        .rst(rst),
        .cmp(cmp.expander)
    );

endmodule

/* rtl/firstBitSeeder.sv */
`timescale 1ns/1ps

module firstBitSeeder (
    input logic clk,
    input logic rst,
    componentIf.seeder cmp
);
    import hypercubePkg::*;

    logic [(1 << (cubeDim - 2)) - 1:0] hasBit4;
    logic [(1 << (cubeDim - 4)) - 1:0] hasBit16;
    logic [(1 << (cubeDim - 4)):0] firstBit16;
    logic [(1 << (cubeDim - 2)) - 1:0] firstBit4;
    graphT seedNext;

    always_comb begin
        // Occupancy per nibble, then per 16-bit group
        for (int n = 0; n < $bits(hasBit4); n++) begin
            hasBit4[n] = |cmp.remaining[4*n +: 4];
        end
        for (int g = 0; g < $bits(hasBit16); g++) begin
            hasBit16[g] = |hasBit4[4*g +: 4];
        end

        // Chain stays high until the first occupied group
        firstBit16[0] = 1'b1;
        for (int g = 1; g <= $bits(hasBit16); g++) begin
            firstBit16[g] = firstBit16[g-1] & ~hasBit16[g-1];
        end

        // Lowest occupied nibble inside the winning group
        for (int g = 0; g < $bits(hasBit16); g++) begin
            firstBit4[4*g] = firstBit16[g] & hasBit4[4*g];
            firstBit4[4*g+1] = firstBit16[g] & ~hasBit4[4*g] & hasBit4[4*g+1];
            firstBit4[4*g+2] = firstBit16[g] & !(|hasBit4[4*g +: 2]) & hasBit4[4*g+2];
            firstBit4[4*g+3] = firstBit16[g] & !(|hasBit4[4*g +: 3]) & hasBit4[4*g+3];
        end

        // Lowest set vertex inside that nibble, one-hot or zero
        for (int n = 0; n < $bits(hasBit4); n++) begin
            seedNext[4*n] = firstBit4[n] & cmp.remaining[4*n];
            seedNext[4*n+1] = firstBit4[n] & ~cmp.remaining[4*n] & cmp.remaining[4*n+1];
            seedNext[4*n+2] = firstBit4[n] & !(|cmp.remaining[4*n +: 2])
                              & cmp.remaining[4*n+2];
            seedNext[4*n+3] = firstBit4[n] & !(|cmp.remaining[4*n +: 3])
                              & cmp.remaining[4*n+3];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmp.empty <= 1'b0;
        end else begin
            // Chain ran through every group, nothing left
            cmp.empty <= firstBit16[$bits(hasBit16)];
        end
    end

    always_ff @(posedge clk) begin
        cmp.seed <= seedNext;
    end

endmodule

/* rtl/hypercubeExpander.sv */
`timescale 1ns/1ps

module hypercubeExpander (
    input logic clk,
    input logic rst,
    componentIf.expander cmp
);
    import hypercubePkg::*;

    graphT grow;
    graphT extNext;

    // Moves every vertex across one cube dimension
    function automatic graphT flipDim(input graphT g, input int d);
        graphT r;
        for (int v = 0; v < vertexCount; v++) begin
            r[v] = g[v ^ (1 << d)];
        end
        return r;
    endfunction

    always_comb begin
        grow = cmp.frontier;
        for (int d = 0; d < cubeDim; d++) begin
            grow = grow | flipDim(cmp.frontier, d);
        end
        // Only vertices not yet assigned to a component may join
        extNext = grow & cmp.remaining;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmp.settled <= 1'b0;
        end else begin
            // No new vertex in this step means the component is complete
            cmp.settled <= (extNext == cmp.frontier);
        end
    end

    always_ff @(posedge clk) begin
        cmp.extended <= extNext;
    end

endmodule

/* rtl/hypercubePkg.sv */
package hypercubePkg;

    // Dimension of the hypercube the graph lives on
    localparam int cubeDim = 7;

    // One vertex per index value
    localparam int vertexCount = 1 << cubeDim;

    // Vertex mask, bit i set means vertex i is present
    typedef logic [vertexCount-1:0] graphT;

    // At most half the vertices can be isolated, so 64 fits in 8 bits
    typedef logic [7:0] countT;

endpackage

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module connectedCountTb -f src.f -o connectedCountSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/connectedCountSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0

/* src.f */
rtl/hypercubePkg.sv
rtl/apbRegPkg.sv
rtl/componentIf.sv
rtl/firstBitSeeder.sv
rtl/hypercubeExpander.sv
rtl/componentController.sv
rtl/apbGraphRegs.sv
rtl/connectedCountTop.sv
tests/connectedCount_assert.sv
tests/connectedCountTb.sv

/* tests/connectedCountTb.sv */
`timescale 1ns/1ps

module connectedCountTb;
    import hypercubePkg::*;
    import apbRegPkg::*;

    localparam int graphWords = vertexCount / apbDataW;
    localparam int cyclesPerCase = 200;
    localparam int marginCycles = 500;
    localparam int fixedCases = 5;
    localparam int randomCases = 20;
    localparam int maxPolls = 400;
    localparam logic [apbDataW-1:0] pattern [4] = '{
        32'h0123_4567, 32'h89AB_CDEF, 32'hFEDC_BA98, 32'h7654_3210
    };

    logic clk;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [apbAddrW-1:0] paddr;
    logic [apbDataW-1:0] pwdata;
    logic [apbDataW-1:0] prdata;
    logic pready;
    logic pslverr;

    int errorCount;
    int checkCount;
    bit stimLoaded;
    logic [31:0] lcgState;
    graphT stimGraph[$];
    int stimCount[$];

    connectedCountTop uut (
        .clk(clk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic finishRun();
        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // Upper half of the state has the longest period
    function automatic logic [15:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    function automatic logic [31:0] randomWord();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = nextRandom();
        lo = nextRandom();
        return {hi, lo};
    endfunction

    // Every extra AND halves the vertex density
    function automatic graphT randomGraph(input int density);
        graphT g;
        logic [31:0] word;
        for (int w = 0; w < graphWords; w++) begin
            word = randomWord();
            for (int k = 0; k < density; k++) begin
                word = word & randomWord();
            end
            g[apbDataW*w +: apbDataW] = word;
        end
        return g;
    endfunction

    // Breadth-first flooding, neighbors differ in exactly one index bit
    function automatic int referenceCount(input graphT g);
        bit seen [vertexCount];
        int queue[$];
        int comps;
        int v;
        int u;
        comps = 0;
        for (int i = 0; i < vertexCount; i++) begin
            seen[i] = 1'b0;
        end
        for (int s = 0; s < vertexCount; s++) begin
            if (g[s] && !seen[s]) begin
                comps++;
                seen[s] = 1'b1;
                queue.push_back(s);
                while (queue.size() > 0) begin
                    v = queue.pop_front();
                    for (int d = 0; d < cubeDim; d++) begin
                        u = v ^ (1 << d);
                        if (g[u] && !seen[u]) begin
                            seen[u] = 1'b1;
                            queue.push_back(u);
                        end
                    end
                end
            end
        end
        return comps;
    endfunction

    task automatic apbWrite(input logic [apbAddrW-1:0] addr, input logic [apbDataW-1:0] data,
                            output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        checkValue("pready in write access", 32'd1, 32'(pready));
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apbRead(input logic [apbAddrW-1:0] addr, output logic [apbDataW-1:0] data,
                           output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err = pslverr;
        checkValue("pready in read access", 32'd1, 32'(pready));
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic writeGraph(input graphT g, input string name);
        logic err;
        for (int w = 0; w < graphWords; w++) begin
            apbWrite(addrGraph0 + apbAddrW'(4 * w), g[apbDataW*w +: apbDataW], err);
            checkValue({name, " graph write"}, 32'd0, 32'(err));
        end
    endtask

    // Polls status until busy drops
    task automatic waitForIdle(output logic [apbDataW-1:0] status);
        logic err;
        int polls;
        bit done;
        polls = 0;
        done = 1'b0;
        while (!done && polls < maxPolls) begin
            apbRead(addrStatus, status, err);
            polls++;
            done = !status[statusBusyBit];
        end
        if (!done) begin
            $display("run still busy after %0d status reads", maxPolls);
            errorCount++;
        end
    endtask

    task automatic runCase(input string name, input graphT g, input int expected);
        logic err;
        logic [apbDataW-1:0] status;
        writeGraph(g, name);
        apbWrite(addrControl, 32'd1, err);
        checkValue({name, " start"}, 32'd0, 32'(err));
        waitForIdle(status);
        checkValue({name, " busy"}, 32'd0, 32'(status[statusBusyBit]));
        checkValue(name, expected, 32'(status[statusCountLsb +: $bits(countT)]));
    endtask

    task automatic loadStimulus();
        int fd;
        string line;
        int got;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        int cnt;
        fd = $fopen("tests/connectedCount_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file tests/connectedCount_stim.txt");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                // Column notes and blank lines do not scan as five fields
                if (got > 0 && $sscanf(line, "%h %h %h %h %d", w0, w1, w2, w3, cnt) == 5) begin
                    stimGraph.push_back({w3, w2, w1, w0});
                    stimCount.push_back(cnt);
                end
            end
            $fclose(fd);
            if (stimGraph.size() == 0) begin
                $display("stimulus file holds no cases");
                errorCount++;
            end
        end
        stimLoaded = 1'b1;
    endtask

    task automatic checkRegisters();
        logic [apbDataW-1:0] rdata;
        logic err;
        apbRead(addrStatus, rdata, err);
        checkValue("reset status", 32'd0, rdata);
        checkValue("reset status err", 32'd0, 32'(err));
        for (int w = 0; w < graphWords; w++) begin
            apbRead(addrGraph0 + apbAddrW'(4 * w), rdata, err);
            checkValue($sformatf("reset graph word %0d", w), 32'd0, rdata);
            apbWrite(addrGraph0 + apbAddrW'(4 * w), pattern[w], err);
        end
        for (int w = 0; w < graphWords; w++) begin
            apbRead(addrGraph0 + apbAddrW'(4 * w), rdata, err);
            checkValue($sformatf("readback graph word %0d", w), pattern[w], rdata);
            checkValue($sformatf("readback err %0d", w), 32'd0, 32'(err));
        end
        apbRead(8'h20, rdata, err);
        checkValue("unmapped read err", 32'd1, 32'(err));
        apbWrite(8'h18, 32'hFFFF_FFFF, err);
        checkValue("unmapped write err", 32'd1, 32'(err));
        apbWrite(addrStatus, 32'hFFFF_FFFF, err);
        checkValue("status write err", 32'd1, 32'(err));
        apbRead(addrStatus, rdata, err);
        checkValue("status after write", 32'd0, rdata);
        for (int w = 0; w < graphWords; w++) begin
            apbRead(addrGraph0 + apbAddrW'(4 * w), rdata, err);
            checkValue($sformatf("graph word %0d after bad writes", w), pattern[w], rdata);
        end
    endtask

    task automatic checkBusyProtection();
        graphT g;
        logic [apbDataW-1:0] rdata;
        logic err;
        countT countBefore;
        // Odd-parity vertices, none adjacent, so the run is long
        g = {32'h9669_6996, 32'h6996_9669, 32'h6996_9669, 32'h9669_6996};
        writeGraph(g, "busy graph");
        apbWrite(addrControl, 32'd1, err);
        apbWrite(addrGraph0, 32'hFFFF_FFFF, err);
        checkValue("graph write while busy err", 32'd1, 32'(err));
        apbRead(addrStatus, rdata, err);
        checkValue("busy during run", 32'd1, 32'(rdata[statusBusyBit]));
        countBefore = rdata[statusCountLsb +: $bits(countT)];
        apbWrite(addrControl, 32'd1, err);
        checkValue("start while busy err", 32'd0, 32'(err));
        // A restart would clear the count
        apbRead(addrStatus, rdata, err);
        checkValue("count kept after start while busy", 32'd1,
                   32'(rdata[statusCountLsb +: $bits(countT)] >= countBefore));
        waitForIdle(rdata);
        checkValue("busy protection count", referenceCount(g),
                   32'(rdata[statusCountLsb +: $bits(countT)]));
        apbRead(addrGraph0, rdata, err);
        checkValue("graph word after busy write", 32'h9669_6996, rdata);
    endtask

    initial begin
        int limitCycles;
        wait (stimLoaded);
        limitCycles = (stimGraph.size() + fixedCases + randomCases) * cyclesPerCase
                      + marginCycles;
        repeat (limitCycles) @(posedge clk);
        $display("simulation timed out after %0d cycles", limitCycles);
        errorCount++;
        finishRun();
    end

    initial begin
        graphT g;
        lcgState = 32'd96;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        loadStimulus();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        checkRegisters();

        runCase("empty graph", '0, 0);
        g = '0;
        g[0] = 1'b1;
        runCase("vertex 0", g, 1);
        g[vertexCount-1] = 1'b1;
        runCase("vertices 0 and 127", g, 2);

        foreach (stimGraph[i]) begin
            runCase($sformatf("file case %0d", i), stimGraph[i], stimCount[i]);
        end

        for (int i = 0; i < randomCases; i++) begin
            g = randomGraph(i % 3);
            runCase($sformatf("random case %0d", i), g, referenceCount(g));
        end

        checkBusyProtection();
        finishRun();
    end

endmodule

/* tests/connectedCount_assert.sv */
`timescale 1ns/1ps

module protocolChecker (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic busy,
    input hypercubePkg::countT count
);

    // No wait states on this slave
    readyHigh: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready low");

    errorInAccess: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else $error("pslverr outside an access phase");

    // Count only moves inside a run
    countHeld: assert property (@(posedge clk) disable iff (rst)
        (!busy && !$past(busy)) |-> (count == $past(count)))
        else $error("count changed while idle");

endmodule

bind connectedCountTop protocolChecker protocolCheck (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .busy(busy),
    .count(count)
);

/* tests/connectedCount_stim.txt */
# word0 word1 word2 word3 expected_count, words in hex, count in decimal
# word0 holds vertices 0 to 31, word3 holds vertices 96 to 127
00000000 00000000 00000000 00000000 0
ffffffff ffffffff ffffffff ffffffff 1
00000001 00000000 00000000 00000000 1
00000009 00000000 00000000 00000000 2
00000007 00000000 00000000 00000000 1
00000006 00000000 00000000 00000000 2
00010001 00000000 00000000 00000000 1
80000001 00000000 00000000 00000000 2
96696996 69969669 69969669 96696996 64
69969669 96696996 96696996 69969669 64
ffffffff 00000000 00000000 ffffffff 2
0000ffff 0000ffff 00000000 00000000 1
0000000f 0000000f 0000000f 0000000f 1
00000000 0000000f 0000000f 00000000 2
00000001 00000000 00000000 80000000 2
